// File: logic/csr_pkg.sv
// Shared widths, CSR addresses, operation codes and identity constants for the CSR unit
package csr_pkg;

  localparam int XLEN = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int COUNTER_W = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [COUNTER_W-1:0] counter_t;
  typedef logic [1:0] priv_t;
  typedef logic [2:0] csr_op_t;
  typedef logic [3:0] csr_id_t;

  // Only user and machine mode exist
  localparam priv_t PRIV_USER = 2'd0;
  localparam priv_t PRIV_MACHINE = 2'd3;

  // Encoded like funct3 of the SYSTEM opcode, bit 2 marks the immediate form
  localparam csr_op_t CSR_OP_NONE = 3'd0;
  localparam csr_op_t CSR_OP_RW = 3'd1;
  localparam csr_op_t CSR_OP_RS = 3'd2;
  localparam csr_op_t CSR_OP_RC = 3'd3;
  localparam csr_op_t CSR_OP_RWI = 3'd5;
  localparam csr_op_t CSR_OP_RSI = 3'd6;
  localparam csr_op_t CSR_OP_RCI = 3'd7;

  localparam csr_addr_t ADDR_MSTATUS = 12'h300;
  localparam csr_addr_t ADDR_MISA = 12'h301;
  localparam csr_addr_t ADDR_MIE = 12'h304;
  localparam csr_addr_t ADDR_MTVEC = 12'h305;
  localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
  localparam csr_addr_t ADDR_MEPC = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE = 12'h342;
  localparam csr_addr_t ADDR_MTVAL = 12'h343;
  localparam csr_addr_t ADDR_MIP = 12'h344;
  localparam csr_addr_t ADDR_CYCLE = 12'hC00;
  localparam csr_addr_t ADDR_INSTRET = 12'hC02;
  localparam csr_addr_t ADDR_CYCLEH = 12'hC80;
  localparam csr_addr_t ADDR_INSTRETH = 12'hC82;
  localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
  localparam csr_addr_t ADDR_MARCHID = 12'hF12;
  localparam csr_addr_t ADDR_MIMPID = 12'hF13;
  localparam csr_addr_t ADDR_MHARTID = 12'hF14;

  // Internal identities; vendor, implementation and hart id all read zero and share one
  localparam csr_id_t CSR_ID_NONE = 4'd0;
  localparam csr_id_t CSR_ID_MSTATUS = 4'd1;
  localparam csr_id_t CSR_ID_MISA = 4'd2;
  localparam csr_id_t CSR_ID_MIE = 4'd3;
  localparam csr_id_t CSR_ID_MTVEC = 4'd4;
  localparam csr_id_t CSR_ID_MSCRATCH = 4'd5;
  localparam csr_id_t CSR_ID_MEPC = 4'd6;
  localparam csr_id_t CSR_ID_MCAUSE = 4'd7;
  localparam csr_id_t CSR_ID_MTVAL = 4'd8;
  localparam csr_id_t CSR_ID_MIP = 4'd9;
  localparam csr_id_t CSR_ID_CYCLE = 4'd10;
  localparam csr_id_t CSR_ID_CYCLEH = 4'd11;
  localparam csr_id_t CSR_ID_INSTRET = 4'd12;
  localparam csr_id_t CSR_ID_INSTRETH = 4'd13;
  localparam csr_id_t CSR_ID_MARCHID = 4'd14;
  localparam csr_id_t CSR_ID_ZERO_ID = 4'd15;

  localparam int MSTATUS_MIE_BIT = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB = 11;

  localparam int MIP_MSIP_BIT = 3;
  localparam int MIP_MTIP_BIT = 7;
  localparam int MIP_MEIP_BIT = 11;

  // mtvec mode field value for vectored traps
  localparam logic [1:0] MTVEC_VECTORED = 2'b01;

  // MXL = 1 (RV32), extensions A, I, M and U
  localparam xlen_t MISA_VALUE = 32'h4010_1101;
  localparam xlen_t MARCHID_VALUE = 32'h0000_002b;

endpackage

// File: logic/csr_decode.sv
// CSR request decoder: address to identity, operand select and access fault check
`timescale 1ns/1ns

module csr_decode (
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::csr_op_t   csr_op,
  input  logic               csr_we,
  input  csr_pkg::xlen_t     rs1_data,
  input  logic [4:0]         uimm,
  input  csr_pkg::priv_t     privilege_mode,
  output csr_pkg::csr_id_t   csr_id,
  output csr_pkg::xlen_t     operand,
  output logic               op_set,
  output logic               op_clear,
  output logic               write_valid,
  output logic               access_fault
);

  logic is_imm;
  logic write_intent;
  logic read_only;
  logic priv_too_low;

  always_comb begin
    case (csr_addr)
      csr_pkg::ADDR_MSTATUS:   csr_id = csr_pkg::CSR_ID_MSTATUS;
      csr_pkg::ADDR_MISA:      csr_id = csr_pkg::CSR_ID_MISA;
      csr_pkg::ADDR_MIE:       csr_id = csr_pkg::CSR_ID_MIE;
      csr_pkg::ADDR_MTVEC:     csr_id = csr_pkg::CSR_ID_MTVEC;
      csr_pkg::ADDR_MSCRATCH:  csr_id = csr_pkg::CSR_ID_MSCRATCH;
      csr_pkg::ADDR_MEPC:      csr_id = csr_pkg::CSR_ID_MEPC;
      csr_pkg::ADDR_MCAUSE:    csr_id = csr_pkg::CSR_ID_MCAUSE;
      csr_pkg::ADDR_MTVAL:     csr_id = csr_pkg::CSR_ID_MTVAL;
      csr_pkg::ADDR_MIP:       csr_id = csr_pkg::CSR_ID_MIP;
      csr_pkg::ADDR_CYCLE:     csr_id = csr_pkg::CSR_ID_CYCLE;
      csr_pkg::ADDR_CYCLEH:    csr_id = csr_pkg::CSR_ID_CYCLEH;
      csr_pkg::ADDR_INSTRET:   csr_id = csr_pkg::CSR_ID_INSTRET;
      csr_pkg::ADDR_INSTRETH:  csr_id = csr_pkg::CSR_ID_INSTRETH;
      csr_pkg::ADDR_MARCHID:   csr_id = csr_pkg::CSR_ID_MARCHID;
      csr_pkg::ADDR_MVENDORID: csr_id = csr_pkg::CSR_ID_ZERO_ID;
      csr_pkg::ADDR_MIMPID:    csr_id = csr_pkg::CSR_ID_ZERO_ID;
      csr_pkg::ADDR_MHARTID:   csr_id = csr_pkg::CSR_ID_ZERO_ID;
      default:                 csr_id = csr_pkg::CSR_ID_NONE;
    endcase
  end

  // Immediate forms carry the zero-extended uimm field
  assign is_imm = (csr_op == csr_pkg::CSR_OP_RWI) ||
                  (csr_op == csr_pkg::CSR_OP_RSI) ||
                  (csr_op == csr_pkg::CSR_OP_RCI);
  assign operand = is_imm ? {27'd0, uimm} : rs1_data;

  assign op_set = (csr_op == csr_pkg::CSR_OP_RS) || (csr_op == csr_pkg::CSR_OP_RSI);
  assign op_clear = (csr_op == csr_pkg::CSR_OP_RC) || (csr_op == csr_pkg::CSR_OP_RCI);

  assign write_intent = csr_we && (csr_op != csr_pkg::CSR_OP_NONE);

  // Address bits 11:10 == 2'b11 mark the read-only space, bits 9:8 the lowest privilege
  assign read_only = (csr_addr[11:10] == 2'b11);
  assign priv_too_low = (csr_addr[9:8] > privilege_mode);

  assign access_fault = (csr_id == csr_pkg::CSR_ID_NONE) || priv_too_low ||
                        (write_intent && read_only);
  assign write_valid = write_intent && !access_fault;

endmodule

// File: logic/csr_execute.sv
// Machine trap registers and privilege mode, updated by CSR writes, trap entry and mret
`timescale 1ns/1ns

module csr_execute (
  input  logic              clk,
  input  logic              resetn,
  input  csr_pkg::csr_id_t  csr_id,
  input  csr_pkg::xlen_t    operand,
  input  logic              op_set,
  input  logic              op_clear,
  input  logic              write_valid,
  input  csr_pkg::xlen_t    rdata,
  input  logic              exception_event,
  input  logic              mret,
  input  csr_pkg::xlen_t    cause,
  input  csr_pkg::xlen_t    pc,
  input  csr_pkg::xlen_t    badaddr,
  output csr_pkg::priv_t    privilege_mode,
  output csr_pkg::xlen_t    mstatus,
  output csr_pkg::xlen_t    mie,
  output csr_pkg::xlen_t    mtvec,
  output csr_pkg::xlen_t    mscratch,
  output csr_pkg::xlen_t    mepc,
  output csr_pkg::xlen_t    mcause,
  output csr_pkg::xlen_t    mtval,
  output csr_pkg::xlen_t    trap_pc,
  output logic              trap_select
);

  csr_pkg::xlen_t wdata;
  csr_pkg::xlen_t mstatus_wr;
  csr_pkg::xlen_t trap_status;
  csr_pkg::xlen_t mret_status;
  csr_pkg::xlen_t trap_base;
  csr_pkg::xlen_t trap_target;
  csr_pkg::priv_t mpp;

  // Read-modify-write result for set and clear forms
  assign wdata = op_clear ? (rdata & ~operand) :
                 op_set   ? (rdata | operand)  : operand;

  assign mpp = mstatus[csr_pkg::MSTATUS_MPP_LSB +: 2];

  always_comb begin
    mstatus_wr = wdata;
    // MPP only holds user or machine
    if (wdata[csr_pkg::MSTATUS_MPP_LSB +: 2] != csr_pkg::PRIV_MACHINE) begin
      mstatus_wr[csr_pkg::MSTATUS_MPP_LSB +: 2] = csr_pkg::PRIV_USER;
    end
  end

  always_comb begin
    trap_status = mstatus;
    trap_status[csr_pkg::MSTATUS_MPIE_BIT] = mstatus[csr_pkg::MSTATUS_MIE_BIT];
    trap_status[csr_pkg::MSTATUS_MIE_BIT] = 1'b0;
    trap_status[csr_pkg::MSTATUS_MPP_LSB +: 2] = privilege_mode;
  end

  always_comb begin
    mret_status = mstatus;
    mret_status[csr_pkg::MSTATUS_MIE_BIT] = mstatus[csr_pkg::MSTATUS_MPIE_BIT];
    mret_status[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    mret_status[csr_pkg::MSTATUS_MPP_LSB +: 2] = csr_pkg::PRIV_USER;
  end

  // Reserved mtvec modes behave as direct
  assign trap_base = {mtvec[31:2], 2'b00};
  assign trap_target = (mtvec[1:0] == csr_pkg::MTVEC_VECTORED) ?
                       trap_base + {cause[29:0], 2'b00} : trap_base;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      privilege_mode <= csr_pkg::PRIV_MACHINE;
      mstatus <= '0;
      mie <= '0;
      mtvec <= '0;
      mscratch <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
      trap_pc <= '0;
      trap_select <= 1'b0;
    end else begin
      trap_select <= 1'b0;
      if (exception_event) begin
        mepc <= pc;
        mcause <= cause;
        mtval <= badaddr;
        mstatus <= trap_status;
        privilege_mode <= csr_pkg::PRIV_MACHINE;
        trap_pc <= trap_target;
        trap_select <= 1'b1;
      end else if (mret) begin
        mstatus <= mret_status;
        privilege_mode <= mpp;
        trap_pc <= mepc;
        trap_select <= 1'b1;
      end else if (write_valid) begin
        // misa, mip and the counters ignore writes
        case (csr_id)
          csr_pkg::CSR_ID_MSTATUS:  mstatus <= mstatus_wr;
          csr_pkg::CSR_ID_MIE:      mie <= wdata;
          csr_pkg::CSR_ID_MTVEC:    mtvec <= wdata;
          csr_pkg::CSR_ID_MSCRATCH: mscratch <= wdata;
          csr_pkg::CSR_ID_MEPC:     mepc <= wdata;
          csr_pkg::CSR_ID_MCAUSE:   mcause <= wdata;
          csr_pkg::CSR_ID_MTVAL:    mtval <= wdata;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: logic/csr_counters.sv
// Free-running cycle counter and retired-instruction counter, both 64 bits wide
`timescale 1ns/1ns

module csr_counters (
  input  logic              clk,
  input  logic              resetn,
  input  logic              instr_retired,
  output csr_pkg::counter_t cycle_count,
  output csr_pkg::counter_t instret_count
);

  // Cycle counts every clock once reset is released
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 64'd1;
    end
  end

  // One step per retirement strobe
  always_ff @(posedge clk) begin
    if (!resetn) begin
      instret_count <= '0;
    end else if (instr_retired) begin
      instret_count <= instret_count + 64'd1;
    end
  end

endmodule

// File: logic/csr_irq.sv
// Samples the machine interrupt lines into mip and gates them into interrupt requests
`timescale 1ns/1ns

module csr_irq (
  input  logic            clk,
  input  logic            resetn,
  input  logic            msip,
  input  logic            mtip,
  input  logic            meip,
  input  logic            hold,
  input  csr_pkg::xlen_t  mie,
  input  csr_pkg::xlen_t  mstatus,
  input  csr_pkg::priv_t  privilege_mode,
  output csr_pkg::xlen_t  mip,
  output logic            irq_software,
  output logic            irq_timer,
  output logic            irq_external
);

  logic irq_enable;

  // mip keeps its value while a trap, mret or CSR write is in progress
  always_ff @(posedge clk) begin
    if (!resetn) begin
      mip <= '0;
    end else if (!hold) begin
      mip <= '0;
      mip[csr_pkg::MIP_MSIP_BIT] <= msip;
      mip[csr_pkg::MIP_MTIP_BIT] <= mtip;
      mip[csr_pkg::MIP_MEIP_BIT] <= meip;
    end
  end

  // Machine interrupts always reach a user-mode hart
  assign irq_enable = (privilege_mode == csr_pkg::PRIV_USER) ||
                      ((privilege_mode == csr_pkg::PRIV_MACHINE) &&
                       mstatus[csr_pkg::MSTATUS_MIE_BIT]);

  assign irq_software = mip[csr_pkg::MIP_MSIP_BIT] & mie[csr_pkg::MIP_MSIP_BIT] & irq_enable;
  assign irq_timer = mip[csr_pkg::MIP_MTIP_BIT] & mie[csr_pkg::MIP_MTIP_BIT] & irq_enable;
  assign irq_external = mip[csr_pkg::MIP_MEIP_BIT] & mie[csr_pkg::MIP_MEIP_BIT] & irq_enable;

endmodule

// File: logic/csr_result.sv
// CSR read multiplexer, returns the value of the identified CSR
`timescale 1ns/1ns

module csr_result (
  input  csr_pkg::csr_id_t  csr_id,
  input  csr_pkg::xlen_t    mstatus,
  input  csr_pkg::xlen_t    mie,
  input  csr_pkg::xlen_t    mtvec,
  input  csr_pkg::xlen_t    mscratch,
  input  csr_pkg::xlen_t    mepc,
  input  csr_pkg::xlen_t    mcause,
  input  csr_pkg::xlen_t    mtval,
  input  csr_pkg::xlen_t    mip,
  input  csr_pkg::counter_t cycle_count,
  input  csr_pkg::counter_t instret_count,
  output csr_pkg::xlen_t    rdata
);

  always_comb begin
    case (csr_id)
      // Writable machine registers
      csr_pkg::CSR_ID_MSTATUS:   rdata = mstatus;
      csr_pkg::CSR_ID_MIE:       rdata = mie;
      csr_pkg::CSR_ID_MTVEC:     rdata = mtvec;
      csr_pkg::CSR_ID_MSCRATCH:  rdata = mscratch;
      csr_pkg::CSR_ID_MEPC:      rdata = mepc;
      csr_pkg::CSR_ID_MCAUSE:    rdata = mcause;
      csr_pkg::CSR_ID_MTVAL:     rdata = mtval;
      // Sampled interrupt lines
      csr_pkg::CSR_ID_MIP:       rdata = mip;
      // Counter halves
      csr_pkg::CSR_ID_CYCLE:     rdata = cycle_count[31:0];
      csr_pkg::CSR_ID_CYCLEH:    rdata = cycle_count[63:32];
      csr_pkg::CSR_ID_INSTRET:   rdata = instret_count[31:0];
      csr_pkg::CSR_ID_INSTRETH:  rdata = instret_count[63:32];
      // Identity constants
      csr_pkg::CSR_ID_MISA:      rdata = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_ID_MARCHID:   rdata = csr_pkg::MARCHID_VALUE;
      csr_pkg::CSR_ID_ZERO_ID:   rdata = '0;
      default:                   rdata = '0;
    endcase
  end

endmodule

// File: logic/csr_unit.sv
// Top of the machine-mode CSR unit, connects decode, execute, counters, interrupts and readback
`timescale 1ns/1ns

module csr_unit (
  input  logic                clk,
  input  logic                resetn,
  input  csr_pkg::csr_addr_t  csr_addr,
  input  csr_pkg::csr_op_t    csr_op,
  input  logic                csr_we,
  input  csr_pkg::xlen_t      rs1_data,
  input  logic [4:0]          uimm,
  input  logic                exception_event,
  input  logic                mret,
  input  csr_pkg::xlen_t      cause,
  input  csr_pkg::xlen_t      pc,
  input  csr_pkg::xlen_t      badaddr,
  input  logic                instr_retired,
  input  logic                msip,
  input  logic                mtip,
  input  logic                meip,
  output csr_pkg::xlen_t      rdata,
  output logic                access_fault,
  output csr_pkg::xlen_t      trap_pc,
  output logic                trap_select,
  output csr_pkg::priv_t      privilege_mode,
  output csr_pkg::xlen_t      mstatus,
  output logic                irq_software,
  output logic                irq_timer,
  output logic                irq_external
);

  csr_pkg::csr_id_t  csr_id;
  csr_pkg::xlen_t    operand;
  logic              op_set;
  logic              op_clear;
  logic              write_valid;
  logic              hold;
  csr_pkg::xlen_t    mie;
  csr_pkg::xlen_t    mtvec;
  csr_pkg::xlen_t    mscratch;
  csr_pkg::xlen_t    mepc;
  csr_pkg::xlen_t    mcause;
  csr_pkg::xlen_t    mtval;
  csr_pkg::xlen_t    mip;
  csr_pkg::counter_t cycle_count;
  csr_pkg::counter_t instret_count;

  // mip sampling pauses whenever the register file is being updated
  assign hold = exception_event || mret || write_valid;

  csr_decode u_decode (
    .csr_addr(csr_addr), .csr_op(csr_op), .csr_we(csr_we), .rs1_data(rs1_data),
    .uimm(uimm), .privilege_mode(privilege_mode), .csr_id(csr_id), .operand(operand),
    .op_set(op_set), .op_clear(op_clear), .write_valid(write_valid),
    .access_fault(access_fault)
  );

  csr_execute u_execute (
    .clk(clk), .resetn(resetn), .csr_id(csr_id), .operand(operand), .op_set(op_set),
    .op_clear(op_clear), .write_valid(write_valid), .rdata(rdata),
    .exception_event(exception_event), .mret(mret), .cause(cause), .pc(pc),
    .badaddr(badaddr), .privilege_mode(privilege_mode), .mstatus(mstatus), .mie(mie),
    .mtvec(mtvec), .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
    .trap_pc(trap_pc), .trap_select(trap_select)
  );

  csr_counters u_counters (
    .clk(clk), .resetn(resetn), .instr_retired(instr_retired),
    .cycle_count(cycle_count), .instret_count(instret_count)
  );

  csr_irq u_irq (
    .clk(clk), .resetn(resetn), .msip(msip), .mtip(mtip), .meip(meip), .hold(hold),
    .mie(mie), .mstatus(mstatus), .privilege_mode(privilege_mode), .mip(mip),
    .irq_software(irq_software), .irq_timer(irq_timer), .irq_external(irq_external)
  );

  csr_result u_result (
    .csr_id(csr_id), .mstatus(mstatus), .mie(mie), .mtvec(mtvec), .mscratch(mscratch),
    .mepc(mepc), .mcause(mcause), .mtval(mtval), .mip(mip), .cycle_count(cycle_count),
    .instret_count(instret_count), .rdata(rdata)
  );

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock (40 ns period) and synchronous active-low reset held for 10 cycles
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Release on a falling edge after ten rising edges in reset
  initial begin
    resetn = 1'b0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;
  end

endmodule

// File: sim/csr_unit_tb.sv
// Self-checking testbench of the CSR unit that runs under Verilator through the Makefile
`timescale 1ns/1ns

module csr_unit_tb;

  localparam int WAIT_LIMIT = 16;

  logic clk;
  logic resetn;
  csr_pkg::csr_addr_t csr_addr;
  csr_pkg::csr_op_t csr_op;
  logic csr_we;
  csr_pkg::xlen_t rs1_data;
  logic [4:0] uimm;
  logic exception_event;
  logic mret;
  csr_pkg::xlen_t cause;
  csr_pkg::xlen_t pc;
  csr_pkg::xlen_t badaddr;
  logic instr_retired;
  logic msip;
  logic mtip;
  logic meip;
  csr_pkg::xlen_t rdata;
  logic access_fault;
  csr_pkg::xlen_t trap_pc;
  logic trap_select;
  csr_pkg::priv_t privilege_mode;
  csr_pkg::xlen_t mstatus;
  logic irq_software;
  logic irq_timer;
  logic irq_external;

  // Shadow state of the model indexed by CSR address
  csr_pkg::xlen_t shadow [0:4095];
  csr_pkg::priv_t shadow_priv;
  int unsigned retired;
  int checks;
  int errors;

  tb_clock_gen u_clock (.clk(clk), .resetn(resetn));

  csr_unit DUT (.*);

  // Expected read value of a CSR
  function automatic csr_pkg::xlen_t expected_read(csr_pkg::csr_addr_t addr);
    case (addr)
      csr_pkg::ADDR_MISA:    return csr_pkg::MISA_VALUE;
      csr_pkg::ADDR_MARCHID: return csr_pkg::MARCHID_VALUE;
      csr_pkg::ADDR_INSTRET: return retired;
      default:               return shadow[addr];
    endcase
  endfunction

  // New register value after a CSR instruction
  function automatic csr_pkg::xlen_t op_result(csr_pkg::csr_op_t op, csr_pkg::xlen_t old_value,
                                                csr_pkg::xlen_t rs1, logic [4:0] imm);
    case (op)
      csr_pkg::CSR_OP_RW:  return rs1;
      csr_pkg::CSR_OP_RS:  return old_value | rs1;
      csr_pkg::CSR_OP_RC:  return old_value & ~rs1;
      csr_pkg::CSR_OP_RWI: return {27'd0, imm};
      csr_pkg::CSR_OP_RSI: return old_value | {27'd0, imm};
      csr_pkg::CSR_OP_RCI: return old_value & ~{27'd0, imm};
      default:             return old_value;
    endcase
  endfunction

  task automatic check_value(string name, csr_pkg::xlen_t expected, csr_pkg::xlen_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // One request per falling edge with outputs sampled 1 ns later
  task automatic drive_request(csr_pkg::csr_addr_t addr, csr_pkg::csr_op_t op, logic we,
                               csr_pkg::xlen_t rs1, logic [4:0] imm);
    @(negedge clk);
    csr_addr = addr;
    csr_op = op;
    csr_we = we;
    rs1_data = rs1;
    uimm = imm;
    exception_event = 1'b0;
    mret = 1'b0;
    #1;
  endtask

  task automatic check_read(string name, csr_pkg::csr_addr_t addr);
    drive_request(addr, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
    check_value(name, expected_read(addr), rdata);
    check_value({name, " fault"}, 0, 32'(access_fault));
  endtask

  // Write and read back one clock later
  task automatic write_csr(csr_pkg::csr_addr_t addr, csr_pkg::csr_op_t op, csr_pkg::xlen_t rs1,
                           logic [4:0] imm);
    drive_request(addr, op, 1'b1, rs1, imm);
    check_value($sformatf("write fault %h", addr), 0, 32'(access_fault));
    shadow[addr] = op_result(op, shadow[addr], rs1, imm);
    check_read($sformatf("op %0d on %h", op, addr), addr);
  endtask

  // Trap pulse comes one clock after the request and lasts one cycle
  task automatic wait_trap(string name, csr_pkg::xlen_t target);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      exception_event = 1'b0;
      mret = 1'b0;
      waited++;
    end while (!trap_select && waited < WAIT_LIMIT);
    if (!trap_select) begin
      errors++;
      $display("%s: trap_select did not rise within %0d cycles", name, WAIT_LIMIT);
    end else begin
      check_value({name, " latency"}, 1, waited);
      check_value({name, " trap_pc"}, target, trap_pc);
      check_value({name, " mode"}, 32'(shadow_priv), 32'(privilege_mode));
      check_value({name, " mstatus"}, shadow[csr_pkg::ADDR_MSTATUS], mstatus);
      @(negedge clk);
      check_value({name, " pulse end"}, 0, 32'(trap_select));
    end
  endtask

  task automatic take_trap(string name, csr_pkg::xlen_t trap_cause, csr_pkg::xlen_t trap_addr,
                           csr_pkg::xlen_t bad);
    csr_pkg::xlen_t status;
    csr_pkg::xlen_t target;
    target = {shadow[csr_pkg::ADDR_MTVEC][31:2], 2'b00};
    if (shadow[csr_pkg::ADDR_MTVEC][1:0] == 2'b01) begin
      target = target + (trap_cause << 2);
    end
    status = shadow[csr_pkg::ADDR_MSTATUS];
    status[csr_pkg::MSTATUS_MPIE_BIT] = status[csr_pkg::MSTATUS_MIE_BIT];
    status[csr_pkg::MSTATUS_MIE_BIT] = 1'b0;
    status[csr_pkg::MSTATUS_MPP_LSB +: 2] = shadow_priv;
    shadow[csr_pkg::ADDR_MSTATUS] = status;
    shadow[csr_pkg::ADDR_MEPC] = trap_addr;
    shadow[csr_pkg::ADDR_MCAUSE] = trap_cause;
    shadow[csr_pkg::ADDR_MTVAL] = bad;
    shadow_priv = csr_pkg::PRIV_MACHINE;
    drive_request(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
    exception_event = 1'b1;
    cause = trap_cause;
    pc = trap_addr;
    badaddr = bad;
    wait_trap(name, target);
    check_read({name, " mepc"}, csr_pkg::ADDR_MEPC);
    check_read({name, " mcause"}, csr_pkg::ADDR_MCAUSE);
    check_read({name, " mtval"}, csr_pkg::ADDR_MTVAL);
  endtask

  task automatic return_from_trap(string name);
    csr_pkg::xlen_t status;
    status = shadow[csr_pkg::ADDR_MSTATUS];
    shadow_priv = status[csr_pkg::MSTATUS_MPP_LSB +: 2];
    status[csr_pkg::MSTATUS_MIE_BIT] = status[csr_pkg::MSTATUS_MPIE_BIT];
    status[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    status[csr_pkg::MSTATUS_MPP_LSB +: 2] = csr_pkg::PRIV_USER;
    shadow[csr_pkg::ADDR_MSTATUS] = status;
    drive_request(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
    mret = 1'b1;
    wait_trap(name, shadow[csr_pkg::ADDR_MEPC]);
  endtask

  initial begin
    #1_000_000;
    $display("Simulation time limit reached before the test sequence ended");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int waited;
    int n;
    csr_pkg::xlen_t count;
    csr_pkg::xlen_t expected_mip;
    logic [2:0] lines;
    logic [2:0] expected_irq;
    logic enable;
    csr_pkg::csr_addr_t reset_addrs [16];
    csr_pkg::csr_addr_t targets [4];
    csr_pkg::csr_op_t ops [6];

    void'($urandom(32'h8a58_78a2));
    csr_addr = '0;
    csr_op = csr_pkg::CSR_OP_NONE;
    csr_we = 1'b0;
    rs1_data = '0;
    uimm = 5'd0;
    exception_event = 1'b0;
    mret = 1'b0;
    cause = '0;
    pc = '0;
    badaddr = '0;
    instr_retired = 1'b0;
    {msip, mtip, meip} = 3'b000;
    for (int a = 0; a < 4096; a++) begin
      shadow[a] = '0;
    end
    shadow_priv = csr_pkg::PRIV_MACHINE;
    retired = 0;
    checks = 0;
    errors = 0;

    waited = 0;
    while (resetn !== 1'b1 && waited < 40) begin
      @(negedge clk);
      waited++;
    end
    if (resetn !== 1'b1) begin
      errors++;
      $display("Reset was not released within 40 cycles");
    end

    // Reset values and identity constants
    reset_addrs = '{csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MISA, csr_pkg::ADDR_MIE,
                    csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MEPC,
                    csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL, csr_pkg::ADDR_MIP,
                    csr_pkg::ADDR_CYCLEH, csr_pkg::ADDR_INSTRET, csr_pkg::ADDR_INSTRETH,
                    csr_pkg::ADDR_MVENDORID, csr_pkg::ADDR_MARCHID, csr_pkg::ADDR_MIMPID,
                    csr_pkg::ADDR_MHARTID};
    foreach (reset_addrs[i]) begin
      check_read($sformatf("reset read %h", reset_addrs[i]), reset_addrs[i]);
    end
    check_value("reset mode", 32'(csr_pkg::PRIV_MACHINE), 32'(privilege_mode));
    check_value("reset outputs", 0,
                32'({trap_select, irq_software, irq_timer, irq_external}));

    // Random CSR operations
    targets = '{csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MIE,
                csr_pkg::ADDR_MEPC};
    ops = '{csr_pkg::CSR_OP_RW, csr_pkg::CSR_OP_RS, csr_pkg::CSR_OP_RC,
            csr_pkg::CSR_OP_RWI, csr_pkg::CSR_OP_RSI, csr_pkg::CSR_OP_RCI};
    for (int i = 0; i < 40; i++) begin
      write_csr(targets[$urandom_range(0, 3)], ops[$urandom_range(0, 5)], $urandom,
                5'($urandom));
    end

    // Access faults
    drive_request(12'h7c5, csr_pkg::CSR_OP_RW, 1'b1, $urandom, 5'd0);
    check_value("unknown address fault", 1, 32'(access_fault));
    check_value("unknown address data", 0, rdata);
    drive_request(csr_pkg::ADDR_CYCLE, csr_pkg::CSR_OP_RW, 1'b1, '0, 5'd0);
    check_value("cycle write fault", 1, 32'(access_fault));
    count = rdata;
    drive_request(csr_pkg::ADDR_CYCLE, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
    check_value("cycle after write", count + 1, rdata);
    // MPP still holds user from reset
    return_from_trap("mret to user");
    drive_request(csr_pkg::ADDR_MSCRATCH, csr_pkg::CSR_OP_RW, 1'b1,
                  ~shadow[csr_pkg::ADDR_MSCRATCH], 5'd0);
    check_value("user mscratch fault", 1, 32'(access_fault));
    take_trap("trap from user", 32'd8, $urandom & 32'hffff_fffc, $urandom);
    check_read("mscratch after user write", csr_pkg::ADDR_MSCRATCH);

    // Direct and vectored trap entry followed by mret
    // uimm 8 sets the MIE bit
    write_csr(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_RSI, '0, 5'd8);
    write_csr(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_OP_RW, $urandom & 32'hffff_fffc, 5'd0);
    take_trap("direct trap", $urandom_range(0, 15), $urandom & 32'hffff_fffc, $urandom);
    write_csr(csr_pkg::ADDR_MTVEC, csr_pkg::CSR_OP_RW, ($urandom & 32'hffff_ff00) | 32'd1,
              5'd0);
    take_trap("vectored trap", $urandom_range(1, 15), $urandom & 32'hffff_fffc, $urandom);
    return_from_trap("mret to machine");

    // Counters
    drive_request(csr_pkg::ADDR_CYCLE, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
    count = rdata;
    n = $urandom_range(3, 20);
    repeat (n) @(negedge clk);
    #1;
    check_value("cycle delta", n, rdata - count);
    for (int i = 0; i < 30; i++) begin
      @(negedge clk);
      instr_retired = 1'($urandom);
      if (instr_retired) begin
        retired++;
      end
    end
    @(negedge clk);
    instr_retired = 1'b0;
    check_read("instret", csr_pkg::ADDR_INSTRET);
    check_read("instreth", csr_pkg::ADDR_INSTRETH);

    // Interrupts with random mie and global enable
    for (int i = 0; i < 24; i++) begin
      write_csr(csr_pkg::ADDR_MIE, csr_pkg::CSR_OP_RW, $urandom, 5'd0);
      write_csr(csr_pkg::ADDR_MSTATUS,
                $urandom_range(0, 1) ? csr_pkg::CSR_OP_RSI : csr_pkg::CSR_OP_RCI, '0, 5'd8);
      lines = 3'($urandom);
      drive_request(csr_pkg::ADDR_MIP, csr_pkg::CSR_OP_NONE, 1'b0, '0, 5'd0);
      {meip, mtip, msip} = lines;
      check_value("irq before sampling", 0, 32'({irq_software, irq_timer, irq_external}));
      expected_mip = '0;
      expected_mip[csr_pkg::MIP_MSIP_BIT] = lines[0];
      expected_mip[csr_pkg::MIP_MTIP_BIT] = lines[1];
      expected_mip[csr_pkg::MIP_MEIP_BIT] = lines[2];
      shadow[csr_pkg::ADDR_MIP] = expected_mip;
      enable = (shadow_priv == csr_pkg::PRIV_USER) ||
               shadow[csr_pkg::ADDR_MSTATUS][csr_pkg::MSTATUS_MIE_BIT];
      expected_irq = {lines[0], lines[1], lines[2]} & {3{enable}} &
                     {shadow[csr_pkg::ADDR_MIE][csr_pkg::MIP_MSIP_BIT],
                      shadow[csr_pkg::ADDR_MIE][csr_pkg::MIP_MTIP_BIT],
                      shadow[csr_pkg::ADDR_MIE][csr_pkg::MIP_MEIP_BIT]};
      check_read("mip", csr_pkg::ADDR_MIP);
      check_value("irq outputs", 32'(expected_irq),
                  32'({irq_software, irq_timer, irq_external}));
      {meip, mtip, msip} = 3'b000;
      shadow[csr_pkg::ADDR_MIP] = '0;
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: csr_unit.f
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_execute.sv
logic/csr_counters.sv
logic/csr_irq.sv
logic/csr_result.sv
logic/csr_unit.sv
sim/tb_clock_gen.sv
sim/csr_unit_tb.sv

// File: Makefile
# Verilator build and run of the CSR unit testbench
SRCS := $(shell grep -v '^+' csr_unit.f)

obj_dir/Vcsr_unit_tb: $(SRCS) csr_unit.f
	verilator --binary --timescale 1ns/1ns --top-module csr_unit_tb -f csr_unit.f -o Vcsr_unit_tb

run: obj_dir/Vcsr_unit_tb
	./obj_dir/Vcsr_unit_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
